// ==== src.f ====
source/filter_cond_pkg.sv
source/mem_response_filter.sv
source/config_word_assembler.sv
source/config_fifo.sv
source/filter_cond_config_loader.sv
dv/tb_model_pkg.sv
dv/tb_filter_cond_config_loader.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_filter_cond_config_loader
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_filter_cond_config_loader.sv ====
module tb_filter_cond_config_loader;
    timeunit 1ns;
    timeprecision 1ps;

    import filter_cond_pkg::*;
    import tb_model_pkg::*;

    localparam int seq_length  = 16;
    localparam int id_relative = 1;
    localparam int fifo_depth  = 16;
    localparam int prog_thresh = 8;
    localparam int win_lo      = id_relative * seq_length;

    // Sequences sent over the whole run
    localparam int num_sequences  = 1 + 3 + 1 + 2 + fifo_depth;
    localparam int timeout_cycles = num_sequences * seq_length * 4 + 200;

    logic          ap_clk;
    logic          reset;
    mem_response_t response_in;
    logic          rd_en;
    config_out_t   config_out;
    fifo_status_t  status;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count = 0;

    filter_cond_config_loader #(
        .seq_length  (seq_length),
        .id_relative (id_relative),
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) uut (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .response_in (response_in),
        .rd_en       (rd_en),
        .config_out  (config_out),
        .status      (status)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------
    // Output checking
    // --------------------
    // Outputs move on the rising edge, sampled here on the falling one
    always @(negedge ap_clk) begin
        if (!reset && config_out.valid) begin
            assert (expected_q.size() != 0) else begin
                $display("Unexpected configuration at %0t with none pending", $time);
                errors++;
            end
            if (expected_q.size() != 0) begin
                assert (config_out.cfg === expected_q[0]) else begin
                    $display("Mismatch at %0t: configuration %h, expected %h",
                        $time, config_out.cfg, expected_q[0]);
                    errors++;
                end
                expected_q.delete(0);
            end
        end
    end

    task automatic check_flag(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    function automatic mem_response_t make_response(input cmd_e cmd, input int unsigned index);
        mem_response_t      r;
        logic [shift_w-1:0] sh;
        sh       = shift_w'({$random(seed)} % 4);
        r.valid  = 1'b1;
        r.cmd    = cmd;
        r.shift  = sh;
        // Bits below the shift fall away in the DUT
        r.offset = offset_w'((index << sh) | ({$random(seed)} & ((1 << sh) - 1)));
        r.data   = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return r;
    endfunction

    // Foreign command inside the window, or a program word outside it
    function automatic mem_response_t make_junk();
        if ($random(seed) & 1) begin
            return make_response(cmd_e'({$random(seed)} % 3), win_lo + {$random(seed)} % 16);
        end
        if ($random(seed) & 1) begin
            return make_response(CMD_MEM_PROGRAM, win_lo + seq_length + {$random(seed)} % 64);
        end
        return make_response(CMD_MEM_PROGRAM, {$random(seed)} % win_lo);
    endfunction

    task automatic send(input mem_response_t r);
        @(negedge ap_clk);
        response_in = r;
        void'(observe(r));
    endtask

    task automatic send_sequence();
        for (int i = 0; i < seq_length; i++) begin
            send(make_response(CMD_MEM_PROGRAM, win_lo + i));
        end
    endtask

    task automatic wait_outputs();
        @(negedge ap_clk);
        response_in.valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge ap_clk);
        end
        // Quiet stretch to catch extra outputs
        repeat (8) @(negedge ap_clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail", tests_run, name);
        end
    endtask

    initial begin
        int start_errors;
        seed         = 32696;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        rd_en        = 1'b0;
        response_in  = '0;
        init_model(seq_length, id_relative);
        repeat (8) @(negedge ap_clk);
        reset = 1'b0;

        start_errors = errors;
        check_flag(config_out.valid, 1'b0, "config_out.valid");
        check_flag(status.empty, 1'b1, "empty");
        check_flag(status.full, 1'b0, "full");
        check_flag(status.prog_full, 1'b0, "prog_full");
        finish_test("reset state", start_errors);

        start_errors = errors;
        rd_en = 1'b1;
        send_sequence();
        wait_outputs();
        finish_test("full sequence decode", start_errors);

        start_errors = errors;
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < seq_length; i++) begin
                if ({$random(seed)} % 2) begin
                    send(make_junk());
                end
                send(make_response(CMD_MEM_PROGRAM, win_lo + i));
            end
        end
        wait_outputs();
        finish_test("filtering", start_errors);

        start_errors = errors;
        send(make_response(CMD_MEM_PROGRAM, win_lo + 1 + {$random(seed)} % (seq_length - 1)));
        wait_outputs();
        send_sequence();
        wait_outputs();
        finish_test("sequence start rule", start_errors);

        start_errors = errors;
        send_sequence();
        send_sequence();
        wait_outputs();
        finish_test("retained fields", start_errors);

        // Back-pressure, FIFO fills up with rd_en low
        start_errors = errors;
        @(negedge ap_clk);
        rd_en = 1'b0;
        check_flag(status.empty, 1'b1, "empty");
        for (int k = 1; k <= fifo_depth; k++) begin
            send_sequence();
            @(negedge ap_clk);
            response_in.valid = 1'b0;
            // Write lands 3 cycles after the last word
            repeat (3) @(negedge ap_clk);
            check_flag(status.empty, 1'b0, "empty");
            check_flag(status.prog_full, k >= prog_thresh, "prog_full");
            check_flag(status.full, k == fifo_depth, "full");
        end
        rd_en = 1'b1;
        wait_outputs();
        check_flag(status.empty, 1'b1, "empty");
        finish_test("back-pressure", start_errors);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== dv/tb_model_pkg.sv ====
package tb_model_pkg;

    import filter_cond_pkg::*;

    int unsigned    seq_len;
    int unsigned    win_start;
    bit             in_seq;
    int unsigned    pos;
    filter_config_t state;
    filter_config_t expected_q[$];

    function automatic void init_model(input int unsigned length, input int unsigned id_rel);
        seq_len   = length;
        win_start = id_rel * length;
        in_seq    = 1'b0;
        pos       = 0;
        state     = '0;
        expected_q.delete();
    endfunction

    // Program command whose shifted offset lands in this engine's window
    function automatic bit selects(input mem_response_t r);
        int unsigned idx;
        idx = r.offset >> r.shift;
        return r.valid && (r.cmd == CMD_MEM_PROGRAM) &&
            (idx >= win_start) && (idx < win_start + seq_len);
    endfunction

    // --------------------
    // Slot decode
    // --------------------
    function automatic void apply_slot(input int unsigned s, input data_t d);
        logic [31:0] w;
        w = d.field[0];
        case (s)
            slot_filter_op:   state.filter_op   = filter_op_e'(w[3:0]);
            slot_filter_mask: state.filter_mask = w[3:0];
            slot_const_mask:  state.const_mask  = w[3:0];
            slot_const_value: state.const_value = d;
            slot_ops_mask:    state.ops_mask    = w[15:0];
            slot_flags: begin
                state.flags.break_flag       = w[0];
                state.flags.break_pass       = w[1];
                state.flags.filter_post      = w[2];
                state.flags.filter_pass      = w[3];
                state.flags.continue_flag    = w[4];
                state.flags.ternary_flag     = w[5];
                state.flags.conditional_flag = w[6];
            end
            slot_route_if: begin
                state.route_if.id_cu     = w[3:0];
                state.route_if.id_bundle = w[7:4];
                state.route_if.id_lane   = w[11:8];
            end
            slot_route_else: begin
                state.route_else.id_cu     = w[3:0];
                state.route_else.id_bundle = w[7:4];
                state.route_else.id_lane   = w[11:8];
            end
            slot_route_ids: begin
                state.route_if.id_engine   = w[3:0];
                state.route_if.id_module   = w[7:4];
                state.route_else.id_engine = w[11:8];
                state.route_else.id_module = w[15:12];
            end
            // Slots past the configuration are consumed only
            default: ;
        endcase
    endfunction

    // Returns 1 when the response completes a sequence
    function automatic bit observe(input mem_response_t r);
        if (!selects(r)) begin
            return 1'b0;
        end
        if (!in_seq) begin
            if ((r.offset >> r.shift) != win_start) begin
                return 1'b0;
            end
            in_seq = 1'b1;
            pos    = 0;
        end else begin
            pos++;
        end
        apply_slot(pos, r.data);
        if (pos == seq_len - 1) begin
            expected_q.push_back(state);
            in_seq = 1'b0;
            return 1'b1;
        end
        return 1'b0;
    endfunction

endpackage

// ==== source/filter_cond_config_loader.sv ====
module filter_cond_config_loader #(
    parameter int seq_length  = 16,
    parameter int id_relative = 0,
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic                           ap_clk,
    input  logic                           reset,
    input  filter_cond_pkg::mem_response_t response_in,
    input  logic                           rd_en,
    output filter_cond_pkg::config_out_t   config_out,
    output filter_cond_pkg::fifo_status_t  status
);
    import filter_cond_pkg::*;

    config_word_t   word;
    logic           cfg_wr_en;
    filter_config_t cfg;

    // --------------------
    // Program word selection
    // --------------------
    mem_response_filter #(
        .seq_length  (seq_length),
        .id_relative (id_relative)
    ) u_filter (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .response_in (response_in),
        .word        (word)
    );

    // --------------------
    // Sequence assembly
    // --------------------
    config_word_assembler #(
        .seq_length (seq_length)
    ) u_assembler (
        .ap_clk (ap_clk),
        .reset  (reset),
        .word   (word),
        .wr_en  (cfg_wr_en),
        .cfg    (cfg)
    );

    // Completed configurations wait here for the consumer
    config_fifo #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) u_fifo (
        .ap_clk     (ap_clk),
        .reset      (reset),
        .wr_en      (cfg_wr_en),
        .din        (cfg),
        .rd_en      (rd_en),
        .config_out (config_out),
        .status     (status)
    );

endmodule

// ==== source/config_fifo.sv ====
module config_fifo #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic                            ap_clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  filter_cond_pkg::filter_config_t din,
    input  logic                            rd_en,
    output filter_cond_pkg::config_out_t    config_out,
    output filter_cond_pkg::fifo_status_t   status
);
    import filter_cond_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    filter_config_t   mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_wr;
    logic             do_rd;

    // Writes into a full buffer are dropped, reads of an empty one ignored
    assign do_wr = wr_en && !status.full;
    assign do_rd = rd_en && !status.empty;

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // Storage and read port
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_rd) begin
            config_out.cfg <= mem[rd_ptr];
        end
        config_out.valid <= do_rd;
        if (reset) begin
            config_out.valid <= 1'b0;
        end
    end

    assign status.full      = (count == fifo_depth);
    assign status.empty     = (count == '0);
    assign status.prog_full = (count >= prog_thresh);

    assert property (@(posedge ap_clk) disable iff (reset) !(wr_en && status.full))
        else $error("configuration written into full FIFO and lost");

    assert property (@(posedge ap_clk) disable iff (reset) count <= fifo_depth)
        else $error("FIFO count above depth");

endmodule

// ==== source/config_word_assembler.sv ====
module config_word_assembler #(
    parameter int seq_length = 16
) (
    input  logic                            ap_clk,
    input  logic                            reset,
    input  filter_cond_pkg::config_word_t   word,
    output logic                            wr_en,
    output filter_cond_pkg::filter_config_t cfg
);
    import filter_cond_pkg::*;

    logic [seq_length-1:0] slot;
    logic                  idle;
    config_word_t          word_q;
    data_t                 d;

    assign idle = (slot == '0);
    assign d    = word_q.data;

    // --------------------
    // Slot sequencer
    // --------------------
    // One-hot position of the word just taken, zero while idle
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            slot  <= '0;
            wr_en <= 1'b0;
        end else begin
            // Last slot seen, the configuration is complete next cycle
            wr_en <= slot[seq_length-1];
            if (word.valid) begin
                if (idle || slot[seq_length-1]) begin
                    // A new sequence may open right behind the one just ended
                    slot <= word.first ? seq_length'(1) : '0;
                end else begin
                    slot <= slot << 1;
                end
            end else if (slot[seq_length-1]) begin
                slot <= '0;
            end
        end
    end

    // Word copy lines up with its slot position
    always_ff @(posedge ap_clk) begin
        word_q <= word;
        if (reset) begin
            word_q.valid <= 1'b0;
        end
    end

    // --------------------
    // Field decode
    // --------------------
    // Fields not hit by a sequence keep their old value
    always_ff @(posedge ap_clk) begin
        if (word_q.valid) begin
            if (slot[slot_filter_op]) begin
                cfg.filter_op <= filter_op_e'(d.field[0][$bits(filter_op_e)-1:0]);
            end
            if (slot[slot_filter_mask]) begin
                cfg.filter_mask <= d.field[0][num_fields-1:0];
            end
            if (slot[slot_const_mask]) begin
                cfg.const_mask <= d.field[0][num_fields-1:0];
            end
            if (slot[slot_const_value]) begin
                cfg.const_value <= d;
            end
            if (slot[slot_ops_mask]) begin
                cfg.ops_mask <= d.field[0][num_fields*num_fields-1:0];
            end
            if (slot[slot_flags]) begin
                cfg.flags.break_flag       <= d.field[0][0];
                cfg.flags.break_pass       <= d.field[0][1];
                cfg.flags.filter_post      <= d.field[0][2];
                cfg.flags.filter_pass      <= d.field[0][3];
                cfg.flags.continue_flag    <= d.field[0][4];
                cfg.flags.ternary_flag     <= d.field[0][5];
                cfg.flags.conditional_flag <= d.field[0][6];
            end
            if (slot[slot_route_if]) begin
                cfg.route_if.id_cu     <= d.field[0][route_id_w-1:0];
                cfg.route_if.id_bundle <= d.field[0][2*route_id_w-1:route_id_w];
                cfg.route_if.id_lane   <= d.field[0][3*route_id_w-1:2*route_id_w];
            end
            if (slot[slot_route_else]) begin
                cfg.route_else.id_cu     <= d.field[0][route_id_w-1:0];
                cfg.route_else.id_bundle <= d.field[0][2*route_id_w-1:route_id_w];
                cfg.route_else.id_lane   <= d.field[0][3*route_id_w-1:2*route_id_w];
            end
            // Engine and module ids of both routes share one word
            if (slot[slot_route_ids]) begin
                cfg.route_if.id_engine   <= d.field[0][route_id_w-1:0];
                cfg.route_if.id_module   <= d.field[0][2*route_id_w-1:route_id_w];
                cfg.route_else.id_engine <= d.field[0][3*route_id_w-1:2*route_id_w];
                cfg.route_else.id_module <= d.field[0][4*route_id_w-1:3*route_id_w];
            end
        end
    end

    assert property (@(posedge ap_clk) disable iff (reset) $onehot0(slot))
        else $error("slot register holds more than one bit");

endmodule

// ==== source/mem_response_filter.sv ====
module mem_response_filter #(
    parameter int seq_length  = 16,
    parameter int id_relative = 0
) (
    input  logic                           ap_clk,
    input  logic                           reset,
    input  filter_cond_pkg::mem_response_t response_in,
    output filter_cond_pkg::config_word_t  word
);
    import filter_cond_pkg::*;

    // Window of sequence indices owned by this engine
    localparam int unsigned win_lo = id_relative * seq_length;
    localparam int unsigned win_hi = win_lo + seq_length;

    mem_response_t       resp_q;
    logic [offset_w-1:0] seq_index;
    logic                is_program;
    logic                in_window;

    // --------------------
    // Input register
    // --------------------
    always_ff @(posedge ap_clk) begin
        resp_q <= response_in;
        if (reset) begin
            resp_q.valid <= 1'b0;
        end
    end

    // --------------------
    // Word selection
    // --------------------
    assign seq_index  = resp_q.offset >> resp_q.shift;
    assign is_program = (resp_q.cmd == CMD_MEM_PROGRAM);
    assign in_window  = (seq_index >= win_lo) && (seq_index < win_hi);

    assign word.valid = resp_q.valid && is_program && in_window;
    // Index 0 of the window opens a new sequence
    assign word.first = (seq_index == win_lo);
    assign word.data  = resp_q.data;

endmodule

// ==== source/filter_cond_pkg.sv ====
package filter_cond_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int offset_w   = 16;
    localparam int shift_w    = 4;
    localparam int num_fields = 4;
    localparam int field_w    = 32;
    localparam int route_id_w = 4;

    // --------------------
    // Slot positions within a sequence
    // --------------------
    localparam int slot_filter_op   = 0;
    localparam int slot_filter_mask = 1;
    localparam int slot_const_mask  = 2;
    localparam int slot_const_value = 3;
    localparam int slot_ops_mask    = 4;
    localparam int slot_flags       = 5;
    localparam int slot_route_if    = 6;
    localparam int slot_route_else  = 7;
    localparam int slot_route_ids   = 8;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [1:0] {
        CMD_INVALID     = 2'd0,
        CMD_MEM_READ    = 2'd1,
        CMD_MEM_WRITE   = 2'd2,
        CMD_MEM_PROGRAM = 2'd3
    } cmd_e;

    typedef enum logic [3:0] {
        FILTER_NOP = 4'd0,
        FILTER_GT  = 4'd1,
        FILTER_LT  = 4'd2,
        FILTER_EQ  = 4'd3,
        FILTER_NE  = 4'd4,
        FILTER_GE  = 4'd5,
        FILTER_LE  = 4'd6
    } filter_op_e;

    // --------------------
    // Structures
    // --------------------
    // field[0] sits in the low 32 bits
    typedef struct packed {
        logic [num_fields-1:0][field_w-1:0] field;
    } data_t;

    typedef struct packed {
        logic                valid;
        cmd_e                cmd;
        logic [offset_w-1:0] offset;
        logic [shift_w-1:0]  shift;
        data_t               data;
    } mem_response_t;

    // One accepted program word, first marks window index 0
    typedef struct packed {
        logic  valid;
        logic  first;
        data_t data;
    } config_word_t;

    typedef struct packed {
        logic [route_id_w-1:0] id_cu;
        logic [route_id_w-1:0] id_bundle;
        logic [route_id_w-1:0] id_lane;
        logic [route_id_w-1:0] id_engine;
        logic [route_id_w-1:0] id_module;
    } route_t;

    typedef struct packed {
        logic break_flag;
        logic break_pass;
        logic filter_post;
        logic filter_pass;
        logic continue_flag;
        logic ternary_flag;
        logic conditional_flag;
    } filter_flags_t;

    typedef struct packed {
        filter_op_e                         filter_op;
        logic [num_fields-1:0]              filter_mask;
        logic [num_fields-1:0]              const_mask;
        data_t                              const_value;
        logic [num_fields*num_fields-1:0]   ops_mask;
        filter_flags_t                      flags;
        route_t                             route_if;
        route_t                             route_else;
    } filter_config_t;

    typedef struct packed {
        logic           valid;
        filter_config_t cfg;
    } config_out_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_status_t;

endpackage
